// File: bench/rv_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    ret_valid_i,
    input rv_core_pkg::arch_word_t ret_pc_i,
    input rv_core_pkg::inst_word_t ret_inst_i,
    input logic                    ret_rd_we_i,
    input rv_core_pkg::rf_addr_t   ret_rd_i
);
    import rv_core_pkg::*;

    logic ctrl_flow_ret;

    assign ctrl_flow_ret = ret_valid_i && ((ret_inst_i[6:0] == OPC_BRANCH) ||
                           (ret_inst_i[6:0] == OPC_JAL) || (ret_inst_i[6:0] == OPC_JALR));

    // once reset has been seen for an edge, retire stays quiet
    assert property (@(posedge clk) rst && $past(rst) |-> !ret_valid_i)
        else $error("retire valid during reset");

    assert property (@(posedge clk) disable iff (rst) ret_rd_we_i |-> (ret_rd_i != 5'd0))
        else $error("register write retired to x0");

    assert property (@(posedge clk) disable iff (rst) ret_valid_i |-> (ret_pc_i[1:0] == 2'b00))
        else $error("misaligned retire pc");

    // fetch inserts one bubble behind every branch or jump
    assert property (@(posedge clk) disable iff (rst) ctrl_flow_ret |=> !ret_valid_i)
        else $error("no bubble after control flow");

endmodule

bind rv_core rv_core_checker u_checker (
    .clk(clk), .rst(rst), .ret_valid_i(ret_valid_o), .ret_pc_i(ret_pc_o),
    .ret_inst_i(ret_inst_o), .ret_rd_we_i(ret_rd_we_o), .ret_rd_i(ret_rd_o)
);

`default_nettype wire

// File: bench/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_core_pkg::*;

    logic clk;
    logic rst;
    inst_word_t imem_data;
    imem_addr_t imem_addr;
    imem_addr_t imem_addr_q;
    logic ret_valid;
    arch_word_t ret_pc;
    inst_word_t ret_inst;
    logic ret_rd_we;
    rf_addr_t ret_rd;
    arch_word_t ret_data;

    logic [31:0] rom [0:1023];
    logic [31:0] mreg [0:31];
    logic [31:0] mpc;
    logic [31:0] lcg_state;
    int wp;
    int errors;
    int checks;
    int cycles;
    int cycle_limit;

    rv_core DUT (
        .clk(clk), .rst(rst), .imem_data_i(imem_data), .imem_addr_o(imem_addr),
        .ret_valid_o(ret_valid), .ret_pc_o(ret_pc), .ret_inst_o(ret_inst),
        .ret_rd_we_o(ret_rd_we), .ret_rd_o(ret_rd), .ret_data_o(ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // rom: address taken on the rising edge, word driven on the falling edge
    always @(posedge clk) imem_addr_q <= imem_addr;
    always @(negedge clk) imem_data <= rom[imem_addr_q];

    // watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the core stopped retiring before the tests ended");
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // RV32I integer semantics, alt is instr bit 30 where it matters
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic put(input logic [31:0] inst);
        rom[wp] = inst;
        wp = wp + 1;
    endtask

    // unreached words are harmless addi x0 with the address as immediate
    task automatic clear_rom();
        for (int i = 0; i < 1024; i++) begin
            rom[i] = i_type(12'(i), 5'd0, 3'd0, 5'd0, OPC_OP_IMM);
        end
        wp = 0;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("Fail %s at pc %h: got %h expected %h", name, mpc, got, exp);
            errors = errors + 1;
        end
    endtask

    // ----------------------------------------
    // reference model, one retirement per call
    task automatic step_and_check();
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] val;
        logic [31:0] npc;
        logic [4:0] rd;
        logic [2:0] f3;
        logic writes;
        logic taken;
        inst = rom[mpc[11:2]];
        rd = inst[11:7];
        f3 = inst[14:12];
        a = mreg[inst[19:15]];
        b = mreg[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        writes = 1'b1;
        val = '0;
        npc = mpc + 32'd4;
        case (inst[6:0])
            OPC_LUI: val = {inst[31:12], 12'b0};
            OPC_AUIPC: val = mpc + {inst[31:12], 12'b0};
            OPC_OP_IMM: val = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
            OPC_OP: val = alu_ref(f3, inst[30], a, b);
            OPC_JAL: begin
                val = mpc + 32'd4;
                npc = mpc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                             inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                val = mpc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                writes = 1'b0;
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    npc = mpc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                 inst[11:8], 1'b0};
                end
            end
            default: writes = 1'b0;
        endcase
        compare_value("ret_pc_o", ret_pc, mpc);
        compare_value("ret_inst_o", ret_inst, inst);
        compare_value("ret_rd_we_o", 32'(ret_rd_we), 32'(writes && (rd != 5'd0)));
        if (writes) begin
            compare_value("ret_rd_o", 32'(ret_rd), 32'(rd));
            compare_value("ret_data_o", ret_data, val);
        end
        if (writes && (rd != 5'd0)) begin
            mreg[rd] = val;
        end
        mpc = npc;
    endtask

    task automatic run_program(input int n);
        int got;
        cycle_limit = cycle_limit + 8 + 20 + 5 * n;
        for (int i = 0; i < 32; i++) begin
            mreg[i] = '0;
        end
        mpc = RESET_VECTOR;
        @(negedge clk);
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        got = 0;
        while (got < n) begin
            @(negedge clk);
            if (ret_valid) begin
                step_and_check();
                got = got + 1;
            end
        end
    endtask

    // ----------------------------------------
    // directed tests
    task automatic forwarding_chain_test();
        clear_rom();
        put(i_type(12'd5, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        put(i_type(12'd7, 5'd1, 3'd0, 5'd2, OPC_OP_IMM));
        put(r_type(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
        put(r_type(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
        put(r_type(7'h00, 5'd3, 5'd4, 3'd4, 5'd5));
        put(i_type(12'd3, 5'd5, 3'd1, 5'd6, OPC_OP_IMM));
        put(r_type(7'h00, 5'd1, 5'd6, 3'd6, 5'd7));
        put(i_type(-12'sd100, 5'd0, 3'd0, 5'd9, OPC_OP_IMM));
        put(i_type({7'h20, 5'd2}, 5'd9, 3'd5, 5'd10, OPC_OP_IMM));
        put(r_type(7'h00, 5'd1, 5'd10, 3'd5, 5'd11));
        put(r_type(7'h00, 5'd9, 5'd11, 3'd3, 5'd12));
        put(r_type(7'h00, 5'd9, 5'd10, 3'd2, 5'd13));
        put(r_type(7'h20, 5'd1, 5'd9, 3'd5, 5'd14));
        put(r_type(7'h00, 5'd14, 5'd14, 3'd7, 5'd15));
        put(i_type(12'hfff, 5'd15, 3'd3, 5'd16, OPC_OP_IMM));
        put(j_type(32'd0, 5'd0));
        run_program(wp + 3);
    endtask

    task automatic upper_and_zero_test();
        clear_rom();
        put(u_type(20'habcde, 5'd1, OPC_LUI));
        put(u_type(20'h12345, 5'd2, OPC_AUIPC));
        put(i_type(12'd5, 5'd1, 3'd0, 5'd0, OPC_OP_IMM));
        put(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd3));
        put(u_type(20'h00077, 5'd0, OPC_LUI));
        put(u_type(20'h00001, 5'd0, OPC_AUIPC));
        put(r_type(7'h00, 5'd0, 5'd0, 3'd6, 5'd4));
        put(i_type(-12'sd1, 5'd1, 3'd0, 5'd5, OPC_OP_IMM));
        put(r_type(7'h00, 5'd2, 5'd5, 3'd0, 5'd6));
        put(j_type(32'd0, 5'd0));
        run_program(wp + 3);
    endtask

    // taken pair skips a poison word, not-taken pair falls into a marker
    task automatic branch_pair(input logic [2:0] f3, input logic [4:0] ta, input logic [4:0] tb,
                               input logic [4:0] na, input logic [4:0] nb);
        put(b_type(32'd8, tb, ta, f3));
        put(i_type(12'd1, 5'd0, 3'd0, 5'd31, OPC_OP_IMM));
        put(b_type(32'd8, nb, na, f3));
        put(i_type(12'(f3), 5'd0, 3'd0, 5'd30, OPC_OP_IMM));
    endtask

    task automatic branch_test();
        clear_rom();
        put(i_type(12'hfff, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        put(i_type(12'd1, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
        branch_pair(3'd0, 5'd1, 5'd1, 5'd1, 5'd2);
        branch_pair(3'd1, 5'd1, 5'd2, 5'd1, 5'd1);
        branch_pair(3'd4, 5'd1, 5'd2, 5'd2, 5'd1);
        branch_pair(3'd5, 5'd2, 5'd1, 5'd1, 5'd2);
        branch_pair(3'd6, 5'd2, 5'd1, 5'd1, 5'd2);
        branch_pair(3'd7, 5'd1, 5'd2, 5'd2, 5'd1);
        // backward loop, three passes
        put(i_type(12'd3, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        put(i_type(12'hfff, 5'd5, 3'd0, 5'd5, OPC_OP_IMM));
        put(b_type(-32'sd4, 5'd0, 5'd5, 3'd1));
        put(j_type(32'd0, 5'd0));
        run_program(wp + 6);
    endtask

    task automatic jump_test();
        clear_rom();
        put(j_type(32'd8, 5'd1));
        put(i_type(12'd1, 5'd0, 3'd0, 5'd31, OPC_OP_IMM));
        put(i_type(12'd21, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        put(i_type(12'd0, 5'd5, 3'd0, 5'd6, OPC_JALR));
        put(i_type(12'd2, 5'd0, 3'd0, 5'd31, OPC_OP_IMM));
        put(i_type(12'd29, 5'd0, 3'd0, 5'd7, OPC_OP_IMM));
        put(i_type(12'd3, 5'd7, 3'd0, 5'd0, OPC_JALR));
        put(i_type(12'd3, 5'd0, 3'd0, 5'd31, OPC_OP_IMM));
        put(r_type(7'h00, 5'd6, 5'd1, 3'd0, 5'd8));
        put(j_type(32'd0, 5'd0));
        run_program(wp + 3);
    endtask

    task automatic random_program_test();
        logic [31:0] r;
        logic [2:0] f3;
        logic [11:0] imm;
        clear_rom();
        for (int i = 1; i < 32; i++) begin
            r = next_rand();
            put(u_type(r[31:12], 5'(i), OPC_LUI));
            put(i_type(r[11:0], 5'(i), 3'd0, 5'(i), OPC_OP_IMM));
        end
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            f3 = r[3:1];
            if (r[0]) begin
                put(r_type(((f3 == 3'd0) || (f3 == 3'd5)) && r[31] ? 7'h20 : 7'h00,
                           r[18:14], r[13:9], f3, r[8:4]));
            end else begin
                imm = r[30:19];
                if (f3 == 3'd1) begin
                    imm = {7'h00, r[23:19]};
                end else if (f3 == 3'd5) begin
                    imm = {r[31] ? 7'h20 : 7'h00, r[23:19]};
                end
                put(i_type(imm, r[13:9], f3, r[8:4], OPC_OP_IMM));
            end
        end
        put(j_type(32'd0, 5'd0));
        run_program(wp + 2);
    endtask

    initial begin
        rst = 1'b1;
        imem_data = '0;
        imem_addr_q = '0;
        lcg_state = 32'd74508;
        errors = 0;
        checks = 0;
        cycles = 0;
        cycle_limit = 0;
        wp = 0;
        forwarding_chain_test();
        upper_and_zero_test();
        branch_test();
        jump_test();
        random_program_test();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
verilog/rv_core_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decoder.sv
verilog/rv_reg_file.sv
verilog/rv_forwarding.sv
verilog/rv_execute.sv
verilog/rv_core.sv
bench/rv_core_checker.sv
bench/rv_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module rv_core_tb -o rv_core_sim
./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_core_pkg::inst_word_t imem_data_i,
    output rv_core_pkg::imem_addr_t imem_addr_o,
    output logic                    ret_valid_o,
    output rv_core_pkg::arch_word_t ret_pc_o,
    output rv_core_pkg::inst_word_t ret_inst_o,
    output logic                    ret_rd_we_o,
    output rv_core_pkg::rf_addr_t   ret_rd_o,
    output rv_core_pkg::arch_word_t ret_data_o
);
    import rv_core_pkg::*;

    arch_word_t pc_dec, imm_dec, rf_rdata_a, rf_rdata_b, rs1_data_dec, rs2_data_dec;
    logic valid_dec, flush, rd_we_dec, branch_dec, jump_dec, jalr_dec;
    rf_addr_t rs1_dec, rs2_dec, rd_dec;
    alu_op_e alu_op_dec, alu_op_exe;
    alu_a_sel_e alu_a_sel_dec, alu_a_sel_exe;
    alu_b_sel_e alu_b_sel_dec, alu_b_sel_exe;
    wb_sel_e wb_sel_dec, wb_sel_exe, wb_sel_wbk;
    logic [2:0] funct3_dec, funct3_exe;
    fwd_sel_e fwd_rs1_dec, fwd_rs2_dec, fwd_rs1_exe, fwd_rs2_exe;

    logic valid_exe, rd_we_exe, branch_exe, jump_exe, jalr_exe;
    arch_word_t pc_exe, imm_exe, rs1_data_exe, rs2_data_exe, result_exe, redirect_pc;
    inst_word_t inst_exe, inst_wbk;
    rf_addr_t rs1_exe, rs2_exe, rd_exe, rd_wbk;
    logic redirect, resolved, valid_wbk, rd_we_wbk;
    arch_word_t pc_wbk, result_wbk, wbk_data;

    // ----------------------------------------
    // fetch and decode
    rv_fetch u_fetch (
        .clk(clk), .rst(rst),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .ctrl_flow_dec_i(branch_dec || jump_dec), .resolved_i(resolved),
        .imem_addr_o(imem_addr_o), .pc_dec_o(pc_dec),
        .valid_dec_o(valid_dec), .flush_o(flush)
    );

    rv_decoder u_decoder (
        .inst_i(imem_data_i),
        .rs1_o(rs1_dec), .rs2_o(rs2_dec), .rd_o(rd_dec), .rd_we_o(rd_we_dec),
        .imm_o(imm_dec), .alu_op_o(alu_op_dec),
        .alu_a_sel_o(alu_a_sel_dec), .alu_b_sel_o(alu_b_sel_dec),
        .wb_sel_o(wb_sel_dec), .branch_o(branch_dec), .jump_o(jump_dec),
        .jalr_o(jalr_dec), .funct3_o(funct3_dec)
    );

    rv_reg_file u_reg_file (
        .clk(clk), .we_i(rd_we_wbk), .waddr_i(rd_wbk), .wdata_i(wbk_data),
        .raddr_a_i(rs1_dec), .raddr_b_i(rs2_dec),
        .rdata_a_o(rf_rdata_a), .rdata_b_o(rf_rdata_b)
    );

    rv_forwarding u_forwarding (
        .rs1_dec_i(rs1_dec), .rs2_dec_i(rs2_dec),
        .rs1_exe_i(rs1_exe), .rs2_exe_i(rs2_exe),
        .rd_wbk_i(rd_wbk), .rd_we_wbk_i(rd_we_wbk),
        .fwd_rs1_dec_o(fwd_rs1_dec), .fwd_rs2_dec_o(fwd_rs2_dec),
        .fwd_rs1_exe_o(fwd_rs1_exe), .fwd_rs2_exe_o(fwd_rs2_exe)
    );

    assign rs1_data_dec = (fwd_rs1_dec == FWD_WBK) ? wbk_data : rf_rdata_a;
    assign rs2_data_dec = (fwd_rs2_dec == FWD_WBK) ? wbk_data : rf_rdata_b;

    // ----------------------------------------
    // decode/execute register
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_exe <= 1'b0;
            rd_we_exe <= 1'b0;
        end else begin
            valid_exe <= valid_dec;
            rd_we_exe <= valid_dec && rd_we_dec;
        end
    end

    always_ff @(posedge clk) begin
        pc_exe <= pc_dec;
        inst_exe <= imem_data_i;
        rs1_exe <= rs1_dec;
        rs2_exe <= rs2_dec;
        rd_exe <= rd_dec;
        imm_exe <= imm_dec;
        rs1_data_exe <= rs1_data_dec;
        rs2_data_exe <= rs2_data_dec;
        alu_op_exe <= alu_op_dec;
        alu_a_sel_exe <= alu_a_sel_dec;
        alu_b_sel_exe <= alu_b_sel_dec;
        wb_sel_exe <= wb_sel_dec;
        branch_exe <= branch_dec;
        jump_exe <= jump_dec;
        jalr_exe <= jalr_dec;
        funct3_exe <= funct3_dec;
    end

    // ----------------------------------------
    // execute
    rv_execute u_execute (
        .pc_i(pc_exe), .rs1_data_i(rs1_data_exe), .rs2_data_i(rs2_data_exe),
        .imm_i(imm_exe), .wbk_data_i(wbk_data),
        .fwd_rs1_i(fwd_rs1_exe), .fwd_rs2_i(fwd_rs2_exe),
        .alu_op_i(alu_op_exe), .alu_a_sel_i(alu_a_sel_exe), .alu_b_sel_i(alu_b_sel_exe),
        .branch_i(branch_exe), .jump_i(jump_exe), .jalr_i(jalr_exe),
        .funct3_i(funct3_exe), .valid_i(valid_exe),
        .result_o(result_exe), .redirect_o(redirect),
        .resolved_o(resolved), .redirect_pc_o(redirect_pc)
    );

    // ----------------------------------------
    // execute/writeback register
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_wbk <= 1'b0;
            rd_we_wbk <= 1'b0;
        end else begin
            valid_wbk <= valid_exe;
            rd_we_wbk <= rd_we_exe;
        end
    end

    always_ff @(posedge clk) begin
        pc_wbk <= pc_exe;
        inst_wbk <= inst_exe;
        rd_wbk <= rd_exe;
        result_wbk <= result_exe;
        wb_sel_wbk <= wb_sel_exe;
    end

    // link value for jal/jalr
    assign wbk_data = (wb_sel_wbk == WB_PC4) ? pc_wbk + 32'd4 : result_wbk;

    assign ret_valid_o = valid_wbk;
    assign ret_pc_o = pc_wbk;
    assign ret_inst_o = inst_wbk;
    assign ret_rd_we_o = rd_we_wbk;
    assign ret_rd_o = rd_wbk;
    assign ret_data_o = wbk_data;

endmodule

`default_nettype wire

// File: verilog/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int IMEM_ADDR_BITS = 10;
    localparam int RESET_FLUSH_CYCLES = 3;

    typedef logic [31:0] arch_word_t;
    typedef logic [31:0] inst_word_t;
    typedef logic [4:0] rf_addr_t;
    typedef logic [IMEM_ADDR_BITS-1:0] imem_addr_t;

    localparam arch_word_t RESET_VECTOR = 32'h0000_0000;

    // base opcodes, inst[6:0]
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {ALU_A_RS1, ALU_A_PC, ALU_A_ZERO} alu_a_sel_e;

    typedef enum logic {ALU_B_RS2, ALU_B_IMM} alu_b_sel_e;

    // writeback source, link value for jumps
    typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;

    typedef enum logic {FWD_NONE, FWD_WBK} fwd_sel_e;

    typedef enum logic {FETCH_RUN, FETCH_BRANCH_WAIT} fetch_state_e;

endpackage

`default_nettype wire

// File: verilog/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  rv_core_pkg::inst_word_t inst_i,
    output rv_core_pkg::rf_addr_t   rs1_o,
    output rv_core_pkg::rf_addr_t   rs2_o,
    output rv_core_pkg::rf_addr_t   rd_o,
    output logic                    rd_we_o,
    output rv_core_pkg::arch_word_t imm_o,
    output rv_core_pkg::alu_op_e    alu_op_o,
    output rv_core_pkg::alu_a_sel_e alu_a_sel_o,
    output rv_core_pkg::alu_b_sel_e alu_b_sel_o,
    output rv_core_pkg::wb_sel_e    wb_sel_o,
    output logic                    branch_o,
    output logic                    jump_o,
    output logic                    jalr_o,
    output logic [2:0]              funct3_o
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic rd_we;
    arch_word_t imm_itype;
    arch_word_t imm_utype;
    arch_word_t imm_btype;
    arch_word_t imm_jtype;

    // funct3 to alu op, alt picks sub or arithmetic shift
    function automatic alu_op_e int_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: int_op = alt ? ALU_SUB : ALU_ADD;
            3'b001: int_op = ALU_SLL;
            3'b010: int_op = ALU_SLT;
            3'b011: int_op = ALU_SLTU;
            3'b100: int_op = ALU_XOR;
            3'b101: int_op = alt ? ALU_SRA : ALU_SRL;
            3'b110: int_op = ALU_OR;
            default: int_op = ALU_AND;
        endcase
    endfunction

    assign opcode = inst_i[6:0];
    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o = inst_i[11:7];
    assign funct3_o = inst_i[14:12];

    assign imm_itype = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_utype = {inst_i[31:12], 12'b0};
    assign imm_btype = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_jtype = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    always_comb begin
        // unknown opcodes fall through as a no-op
        rd_we = 1'b0;
        imm_o = '0;
        alu_op_o = ALU_ADD;
        alu_a_sel_o = ALU_A_ZERO;
        alu_b_sel_o = ALU_B_IMM;
        wb_sel_o = WB_ALU;
        branch_o = 1'b0;
        jump_o = 1'b0;
        jalr_o = 1'b0;
        case (opcode)
            OPC_LUI: begin
                rd_we = 1'b1;
                imm_o = imm_utype;
                alu_op_o = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                rd_we = 1'b1;
                imm_o = imm_utype;
                alu_a_sel_o = ALU_A_PC;
            end
            OPC_OP_IMM: begin
                rd_we = 1'b1;
                imm_o = imm_itype;
                alu_a_sel_o = ALU_A_RS1;
                // bit 30 only means srai here, addi keeps it as immediate
                alu_op_o = int_op(funct3_o, (funct3_o == 3'b101) && inst_i[30]);
            end
            OPC_OP: begin
                rd_we = 1'b1;
                alu_a_sel_o = ALU_A_RS1;
                alu_b_sel_o = ALU_B_RS2;
                alu_op_o = int_op(funct3_o, inst_i[30]);
            end
            OPC_BRANCH: begin
                imm_o = imm_btype;
                alu_a_sel_o = ALU_A_PC;
                branch_o = 1'b1;
            end
            OPC_JAL: begin
                rd_we = 1'b1;
                imm_o = imm_jtype;
                alu_a_sel_o = ALU_A_PC;
                wb_sel_o = WB_PC4;
                jump_o = 1'b1;
            end
            OPC_JALR: begin
                rd_we = 1'b1;
                imm_o = imm_itype;
                alu_a_sel_o = ALU_A_RS1;
                wb_sel_o = WB_PC4;
                jump_o = 1'b1;
                jalr_o = 1'b1;
            end
            default: begin
                rd_we = 1'b0;
            end
        endcase
    end

    assign rd_we_o = rd_we && (rd_o != '0);

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  rv_core_pkg::arch_word_t pc_i,
    input  rv_core_pkg::arch_word_t rs1_data_i,
    input  rv_core_pkg::arch_word_t rs2_data_i,
    input  rv_core_pkg::arch_word_t imm_i,
    input  rv_core_pkg::arch_word_t wbk_data_i,
    input  rv_core_pkg::fwd_sel_e   fwd_rs1_i,
    input  rv_core_pkg::fwd_sel_e   fwd_rs2_i,
    input  rv_core_pkg::alu_op_e    alu_op_i,
    input  rv_core_pkg::alu_a_sel_e alu_a_sel_i,
    input  rv_core_pkg::alu_b_sel_e alu_b_sel_i,
    input  logic                    branch_i,
    input  logic                    jump_i,
    input  logic                    jalr_i,
    input  logic [2:0]              funct3_i,
    input  logic                    valid_i,
    output rv_core_pkg::arch_word_t result_o,
    output logic                    redirect_o,
    output logic                    resolved_o,
    output rv_core_pkg::arch_word_t redirect_pc_o
);
    import rv_core_pkg::*;

    arch_word_t rs1;
    arch_word_t rs2;
    arch_word_t op_a;
    arch_word_t op_b;
    logic a_eq_b;
    logic a_lt_b;
    logic a_ltu_b;
    logic taken;

    assign rs1 = (fwd_rs1_i == FWD_WBK) ? wbk_data_i : rs1_data_i;
    assign rs2 = (fwd_rs2_i == FWD_WBK) ? wbk_data_i : rs2_data_i;

    always_comb begin
        case (alu_a_sel_i)
            ALU_A_RS1: op_a = rs1;
            ALU_A_PC: op_a = pc_i;
            default: op_a = '0;
        endcase
    end

    assign op_b = (alu_b_sel_i == ALU_B_IMM) ? imm_i : rs2;

    // ----------------------------------------
    // alu
    always_comb begin
        result_o = op_a + op_b;
        case (alu_op_i)
            ALU_SUB: result_o = op_a - op_b;
            ALU_SLL: result_o = op_a << op_b[4:0];
            ALU_SLT: result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result_o = {31'b0, op_a < op_b};
            ALU_XOR: result_o = op_a ^ op_b;
            ALU_SRL: result_o = op_a >> op_b[4:0];
            ALU_SRA: result_o = $signed(op_a) >>> op_b[4:0];
            ALU_OR: result_o = op_a | op_b;
            ALU_AND: result_o = op_a & op_b;
            ALU_PASS_B: result_o = op_b;
            default: result_o = op_a + op_b;
        endcase
    end

    // ----------------------------------------
    // branch compare, alu already holds the target
    assign a_eq_b = (rs1 == rs2);
    assign a_lt_b = ($signed(rs1) < $signed(rs2));
    assign a_ltu_b = (rs1 < rs2);

    always_comb begin
        case (funct3_i)
            3'b000: taken = a_eq_b;
            3'b001: taken = !a_eq_b;
            3'b100: taken = a_lt_b;
            3'b101: taken = !a_lt_b;
            3'b110: taken = a_ltu_b;
            3'b111: taken = !a_ltu_b;
            default: taken = 1'b0;
        endcase
    end

    assign resolved_o = valid_i && (branch_i || jump_i);
    assign redirect_o = valid_i && (jump_i || (branch_i && taken));
    // jalr drops bit 0 of rs1+imm
    assign redirect_pc_o = {result_o[31:1], result_o[0] & !jalr_i};

endmodule

`default_nettype wire

// File: verilog/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect_i,
    input  rv_core_pkg::arch_word_t redirect_pc_i,
    input  logic                    ctrl_flow_dec_i,
    input  logic                    resolved_i,
    output rv_core_pkg::imem_addr_t imem_addr_o,
    output rv_core_pkg::arch_word_t pc_dec_o,
    output logic                    valid_dec_o,
    output logic                    flush_o
);
    import rv_core_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;
    arch_word_t pc_q;
    arch_word_t pc_next;
    logic [RESET_FLUSH_CYCLES-1:0] flush_seq;

    // ones shift out one per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_seq <= '1;
        end else begin
            flush_seq <= {flush_seq[RESET_FLUSH_CYCLES-2:0], 1'b0};
        end
    end

    assign flush_o = flush_seq[RESET_FLUSH_CYCLES-1];

    always_comb begin
        state_d = state_q;
        pc_next = pc_q + 32'd4;
        if (flush_o) begin
            // sit on the reset vector until the flush drains
            pc_next = pc_q;
        end else if (state_q == FETCH_RUN) begin
            if (ctrl_flow_dec_i) begin
                pc_next = pc_q;
                state_d = FETCH_BRANCH_WAIT;
            end
        end else if (resolved_i) begin
            pc_next = redirect_i ? redirect_pc_i : pc_q + 32'd4;
            state_d = FETCH_RUN;
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FETCH_RUN;
            pc_q <= RESET_VECTOR;
        end else begin
            state_q <= state_d;
            pc_q <= pc_next;
        end
    end

    // rom answers one edge later, so pc_q lines up with imem data
    assign imem_addr_o = pc_next[IMEM_ADDR_BITS+1:2];
    assign pc_dec_o = pc_q;
    // repeated word in branch wait is a bubble
    assign valid_dec_o = !flush_o && (state_q == FETCH_RUN);

endmodule

`default_nettype wire

// File: verilog/rv_forwarding.sv
`timescale 1ns/1ps
`default_nettype none

module rv_forwarding (
    input  rv_core_pkg::rf_addr_t rs1_dec_i,
    input  rv_core_pkg::rf_addr_t rs2_dec_i,
    input  rv_core_pkg::rf_addr_t rs1_exe_i,
    input  rv_core_pkg::rf_addr_t rs2_exe_i,
    input  rv_core_pkg::rf_addr_t rd_wbk_i,
    input  logic                  rd_we_wbk_i,
    output rv_core_pkg::fwd_sel_e fwd_rs1_dec_o,
    output rv_core_pkg::fwd_sel_e fwd_rs2_dec_o,
    output rv_core_pkg::fwd_sel_e fwd_rs1_exe_o,
    output rv_core_pkg::fwd_sel_e fwd_rs2_exe_o
);
    import rv_core_pkg::*;

    // match against the one writer in flight, x0 never forwards
    function automatic fwd_sel_e pick(input rf_addr_t rs, input rf_addr_t rd,
                                      input logic we);
        pick = (we && (rs != '0) && (rs == rd)) ? FWD_WBK : FWD_NONE;
    endfunction

    // decode side covers the regfile write-through case
    assign fwd_rs1_dec_o = pick(rs1_dec_i, rd_wbk_i, rd_we_wbk_i);
    assign fwd_rs2_dec_o = pick(rs2_dec_i, rd_wbk_i, rd_we_wbk_i);

    // execute side covers back-to-back dependencies
    assign fwd_rs1_exe_o = pick(rs1_exe_i, rd_wbk_i, rd_we_wbk_i);
    assign fwd_rs2_exe_o = pick(rs2_exe_i, rd_wbk_i, rd_we_wbk_i);

endmodule

`default_nettype wire

// File: verilog/rv_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file (
    input  logic                    clk,
    input  logic                    we_i,
    input  rv_core_pkg::rf_addr_t   waddr_i,
    input  rv_core_pkg::arch_word_t wdata_i,
    input  rv_core_pkg::rf_addr_t   raddr_a_i,
    input  rv_core_pkg::rf_addr_t   raddr_b_i,
    output rv_core_pkg::arch_word_t rdata_a_o,
    output rv_core_pkg::arch_word_t rdata_b_o
);
    import rv_core_pkg::*;

    // x0 has no storage
    arch_word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // old value on a same-cycle write, forwarding covers it
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire
